/* logic/gamate_video_defs.svh */
`ifndef GAMATE_VIDEO_DEFS_SVH
`define GAMATE_VIDEO_DEFS_SVH

// Frame buffer address bits, covers 160x150 shades
`define GV_FB_ADDR_W 15

// Line buffer entries, one per column
`define GV_LINE_DEPTH 256

// Bits per colour channel
`define GV_CH_W 8

// Custom palette bytes, four colours of r, g, b
`define GV_PAL_BYTES 12

`endif

/* logic/gamate_video_pkg.sv */
`include "gamate_video_defs.svh"

package gamate_video_pkg;

	// Shade code from the video core, SHADE_0 is the lightest
	typedef enum logic [1:0] {
		SHADE_0 = 2'd0,
		SHADE_1 = 2'd1,
		SHADE_2 = 2'd2,
		SHADE_3 = 2'd3
	} shade_e;

	typedef struct packed {
		logic [`GV_CH_W-1:0] r;
		logic [`GV_CH_W-1:0] g;
		logic [`GV_CH_W-1:0] b;
	} rgb_t;

	// One colour per shade, indexed by shade_e
	typedef rgb_t [3:0] palette_t;

	localparam palette_t default_palette = '{
		0: '{r: 8'h82, g: 8'h82, b: 8'h14},
		1: '{r: 8'h51, g: 8'h73, b: 8'h56},
		2: '{r: 8'h30, g: 8'h5A, b: 8'h5F},
		3: '{r: 8'h1A, g: 8'h3B, b: 8'h49}
	};

	// Power-up contents of the writable palette
	localparam palette_t custom_reset_palette = '{
		0: '{r: 8'hF7, g: 8'hBE, b: 8'hF7},
		1: '{r: 8'hE7, g: 8'h86, b: 8'h86},
		2: '{r: 8'h77, g: 8'h33, b: 8'hE7},
		3: '{r: 8'h2C, g: 8'h2C, b: 8'h96}
	};

endpackage

/* logic/pixel_if.sv */
`timescale 1ns/1ns

// Free-running pixel stream, one pixel per ce strobe
interface pixel_if;
	logic ce;
	gamate_video_pkg::shade_e shade;
	logic hblank;
	logic vblank;
	logic vsync;

	modport source (
		output ce,
		output shade,
		output hblank,
		output vblank,
		output vsync
	);

	modport sink (
		input ce,
		input shade,
		input hblank,
		input vblank,
		input vsync
	);
endinterface

/* logic/frame_history.sv */
`timescale 1ns/1ns
`include "gamate_video_defs.svh"

module frame_history #(
	parameter int H_ACTIVE = 160,
	parameter int V_ACTIVE = 150
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	pixel_if.sink                    pix,
	output gamate_video_pkg::shade_e prev_shade
);

	localparam int ADDR_W = `GV_FB_ADDR_W;
	localparam int FB_DEPTH = 1 << ADDR_W;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(H_ACTIVE * V_ACTIVE);

	gamate_video_pkg::shade_e ram [FB_DEPTH];
	gamate_video_pkg::shade_e rd_q;

	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic              active;
	logic              seen_active;
	logic              have_frame;

	assign active = pix.ce && !pix.hblank && !pix.vblank;

	// Look-ahead address of the pixel that the next ce presents
	always_comb begin
		if (pix.vsync)
			rd_addr = '0;
		else if (active)
			rd_addr = wr_addr + 1'b1;
		else
			rd_addr = wr_addr;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_addr     <= '0;
			seen_active <= 1'b0;
			have_frame  <= 1'b0;
		end else begin
			wr_addr <= rd_addr;
			if (active)
				seen_active <= 1'b1;
			// a full frame has gone into the buffer
			if (pix.vsync && seen_active)
				have_frame <= 1'b1;
		end
	end

	// Write the current shade, prefetch the next pixel's history
	always_ff @(posedge clk_sys) begin
		if (active)
			ram[wr_addr] <= pix.shade;
		rd_q <= ram[rd_addr];
	end

	// Without history the pixel is blended with itself
	assign prev_shade = have_frame ? rd_q : pix.shade;

	a_ce_gap: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pix.ce |=> !pix.ce
	) else $error("pixel enable high on two consecutive cycles");

	a_addr_bound: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wr_addr <= LAST_ADDR
	) else $error("frame buffer address beyond active area");

	// No active pixel may be counted during the vsync line
	a_addr_restart: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pix.vsync |-> !active
	) else $error("active pixel during vsync, frame buffer address not restarted at zero");

endmodule

/* logic/shadow_line.sv */
`timescale 1ns/1ns
`include "gamate_video_defs.svh"

module shadow_line (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	pixel_if.sink                    pix,
	output gamate_video_pkg::shade_e above_shade
);

	localparam int DEPTH = `GV_LINE_DEPTH;
	// One spare bit so an overlong line shows up in the check below
	localparam int COL_W = $clog2(DEPTH) + 1;

	gamate_video_pkg::shade_e line_buf [DEPTH];

	logic [COL_W-1:0] col;
	logic [COL_W-2:0] idx;

	assign idx = col[COL_W-2:0];

	// Entry still holds the shade written one line earlier
	assign above_shade = line_buf[idx];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			col <= '0;
		else if (pix.hblank)
			col <= '0;
		else if (pix.ce)
			col <= col + 1'b1;
	end

	// Vblank lines flush the buffer so the first line is never shadowed
	always_ff @(posedge clk_sys) begin
		if (pix.ce && !pix.hblank)
			line_buf[idx] <= pix.vblank ? gamate_video_pkg::SHADE_0 : pix.shade;
	end

	a_col_bound: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pix.ce && !pix.hblank |-> col < COL_W'(DEPTH)
	) else $error("line longer than the shadow line buffer");

endmodule

/* logic/palette_blend.sv */
`timescale 1ns/1ns
`include "gamate_video_defs.svh"

module palette_blend (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	pixel_if.sink                    pix,
	input  gamate_video_pkg::shade_e prev_shade,
	input  gamate_video_pkg::shade_e above_shade,
	input  logic                     blend_en,
	input  logic                     shadow_en,
	input  logic                     custom_pal,
	input  logic                     pal_wr,
	input  logic [3:0]               pal_addr,
	input  logic [7:0]               pal_data,
	output gamate_video_pkg::rgb_t   rgb,
	output logic                     de
);

	localparam int CH_W = `GV_CH_W;

	gamate_video_pkg::palette_t custom_q;
	gamate_video_pkg::palette_t sel_pal;
	gamate_video_pkg::rgb_t     cur;
	gamate_video_pkg::rgb_t     prv;
	gamate_video_pkg::rgb_t     blended;
	gamate_video_pkg::rgb_t     shaded;

	logic [1:0] wr_col;
	logic [1:0] wr_byte;
	logic       do_shadow;
	logic       de_next;

	// Floor of the average, sum kept one bit wider
	function automatic logic [CH_W-1:0] blend_ch(
		input logic [CH_W-1:0] c,
		input logic [CH_W-1:0] p,
		input logic            en
	);
		logic [CH_W:0] sum;
		sum = {1'b0, c} + {1'b0, p};
		return en ? sum[CH_W:1] : c;
	endfunction

	// Darker shades above leave less of the channel
	function automatic logic [CH_W-1:0] shadow_ch(
		input logic [CH_W-1:0]        v,
		input gamate_video_pkg::shade_e above,
		input logic                   en
	);
		logic [1:0]      ab;
		logic [CH_W-1:0] s;
		ab = above;
		s = (v >> 1) + (v >> 2);
		if (!ab[1])
			s = s + (v >> 3);
		if (!ab[0])
			s = s + (v >> 4);
		return en ? s : v;
	endfunction

	// Byte address is colour times three plus channel
	assign wr_col = 2'(pal_addr / 4'd3);
	assign wr_byte = 2'(pal_addr % 4'd3);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			custom_q <= gamate_video_pkg::custom_reset_palette;
		end else if (pal_wr) begin
			case (wr_byte)
				2'd0:    custom_q[wr_col].r <= pal_data;
				2'd1:    custom_q[wr_col].g <= pal_data;
				default: custom_q[wr_col].b <= pal_data;
			endcase
		end
	end

	assign sel_pal = custom_pal ? custom_q : gamate_video_pkg::default_palette;
	assign cur = sel_pal[pix.shade];
	assign prv = sel_pal[prev_shade];

	assign blended.r = blend_ch(cur.r, prv.r, blend_en);
	assign blended.g = blend_ch(cur.g, prv.g, blend_en);
	assign blended.b = blend_ch(cur.b, prv.b, blend_en);

	// Only a light pixel under a darker one casts the shadow
	assign do_shadow = shadow_en
		&& (pix.shade == gamate_video_pkg::SHADE_0)
		&& (above_shade != gamate_video_pkg::SHADE_0);

	assign shaded.r = shadow_ch(blended.r, above_shade, do_shadow);
	assign shaded.g = shadow_ch(blended.g, above_shade, do_shadow);
	assign shaded.b = shadow_ch(blended.b, above_shade, do_shadow);

	assign de_next = !pix.hblank && !pix.vblank;

	// Output holds until the next pixel strobe
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= '0;
			de  <= 1'b0;
		end else if (pix.ce) begin
			rgb <= de_next ? shaded : '0;
			de  <= de_next;
		end
	end

	a_pal_addr: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pal_wr |-> pal_addr < 4'(`GV_PAL_BYTES)
	) else $error("palette write outside the custom palette");

endmodule

/* logic/gamate_video.sv */
`timescale 1ns/1ns
`include "gamate_video_defs.svh"

module gamate_video #(
	parameter int H_ACTIVE = 160,
	parameter int V_ACTIVE = 150
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               pix_ce,
	input  logic [1:0]         pix_shade,
	input  logic               pix_hblank,
	input  logic               pix_vblank,
	input  logic               pix_vsync,
	input  logic               blend_en,
	input  logic               shadow_en,
	input  logic               custom_pal,
	input  logic               pal_wr,
	input  logic [3:0]         pal_addr,
	input  logic [7:0]         pal_data,
	output logic [`GV_CH_W-1:0] rgb_r,
	output logic [`GV_CH_W-1:0] rgb_g,
	output logic [`GV_CH_W-1:0] rgb_b,
	output logic               de
);

	pixel_if pix ();

	gamate_video_pkg::shade_e prev_shade;
	gamate_video_pkg::shade_e above_shade;
	gamate_video_pkg::rgb_t   rgb;

	assign pix.ce     = pix_ce;
	assign pix.shade  = gamate_video_pkg::shade_e'(pix_shade);
	assign pix.hblank = pix_hblank;
	assign pix.vblank = pix_vblank;
	assign pix.vsync  = pix_vsync;

	frame_history #(
		.H_ACTIVE (H_ACTIVE),
		.V_ACTIVE (V_ACTIVE)
	) u_frame_history (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.pix        (pix.sink),
		.prev_shade (prev_shade)
	);

	shadow_line u_shadow_line (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.pix         (pix.sink),
		.above_shade (above_shade)
	);

	palette_blend u_palette_blend (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.pix         (pix.sink),
		.prev_shade  (prev_shade),
		.above_shade (above_shade),
		.blend_en    (blend_en),
		.shadow_en   (shadow_en),
		.custom_pal  (custom_pal),
		.pal_wr      (pal_wr),
		.pal_addr    (pal_addr),
		.pal_data    (pal_data),
		.rgb         (rgb),
		.de          (de)
	);

	assign rgb_r = rgb.r;
	assign rgb_g = rgb.g;
	assign rgb_b = rgb.b;

endmodule

/* tb/gamate_video_tb.sv */
`timescale 1ns/1ns
`include "gamate_video_defs.svh"

module gamate_video_tb;

	localparam int H_ACT = 16;
	localparam int V_ACT = 8;
	localparam int H_BLANK = 4;
	localparam int V_BLANK = 2;
	localparam int CE_DIV = 4;
	localparam int RESET_CYCLES = 8;
	localparam int FRAMES = 3;
	localparam int ROWS = 10;
	localparam int CH_W = `GV_CH_W;
	localparam int PAL_BYTES = `GV_PAL_BYTES;
	localparam int FRAME_CYCLES = (H_ACT + H_BLANK) * (V_ACT + V_BLANK) * CE_DIV;
	localparam int CYCLE_LIMIT = (ROWS * FRAMES * FRAME_CYCLES + RESET_CYCLES) * 2;

	localparam logic [1:0] MODE_RANDOM = 2'd0;
	localparam logic [1:0] MODE_ZERO = 2'd1;
	localparam logic [1:0] MODE_CHECKER = 2'd2;

	typedef struct packed {
		bit         blend;
		bit         shadow;
		bit         custom;
		logic [3:0] n_writes;
		logic [1:0] mode;
		bit         mid_reset;
	} row_t;

	// blend, shadow, custom palette, palette writes, shade mode, reset inside the row
	localparam row_t ROW_TBL [ROWS] = '{
		'{1'b0, 1'b0, 1'b0, 4'd0, MODE_RANDOM, 1'b0},
		'{1'b0, 1'b0, 1'b1, 4'd0, MODE_RANDOM, 1'b0},
		'{1'b0, 1'b0, 1'b1, 4'd5, MODE_RANDOM, 1'b0},
		'{1'b1, 1'b0, 1'b0, 4'd0, MODE_RANDOM, 1'b0},
		'{1'b0, 1'b1, 1'b0, 4'd0, MODE_CHECKER, 1'b0},
		'{1'b0, 1'b1, 1'b1, 4'd0, MODE_ZERO, 1'b0},
		'{1'b1, 1'b1, 1'b1, 4'd7, MODE_RANDOM, 1'b0},
		'{1'b1, 1'b0, 1'b1, 4'd0, MODE_RANDOM, 1'b1},
		'{1'b1, 1'b1, 1'b1, 4'd12, MODE_CHECKER, 1'b0},
		'{1'b1, 1'b1, 1'b0, 4'd0, MODE_RANDOM, 1'b0}
	};

	localparam logic [7:0] WR_BYTES [PAL_BYTES] = '{
		8'h0F, 8'hE1, 8'h3C, 8'hA5, 8'h5A, 8'hC3,
		8'h96, 8'h69, 8'hFF, 8'h00, 8'h7E, 8'h81
	};

	logic            clk_sys;
	logic            rst_n;
	logic            pix_ce;
	logic [1:0]      pix_shade;
	logic            pix_hblank;
	logic            pix_vblank;
	logic            pix_vsync;
	logic            blend_en;
	logic            shadow_en;
	logic            custom_pal;
	logic            pal_wr;
	logic [3:0]      pal_addr;
	logic [7:0]      pal_data;
	logic [CH_W-1:0] rgb_r;
	logic [CH_W-1:0] rgb_g;
	logic [CH_W-1:0] rgb_b;
	logic            de;

	// Reference model state
	gamate_video_pkg::shade_e   ref_prev [H_ACT * V_ACT];
	gamate_video_pkg::shade_e   ref_line [H_ACT];
	gamate_video_pkg::palette_t ref_custom;
	bit                         ref_have_frame;
	bit                         ref_seen_active;

	int seed = 32'h92e0_925f;
	int cycles = 0;
	int wr_cnt = 0;

	gamate_video #(
		.H_ACTIVE (H_ACT),
		.V_ACTIVE (V_ACT)
	) UUT (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.pix_ce     (pix_ce),
		.pix_shade  (pix_shade),
		.pix_hblank (pix_hblank),
		.pix_vblank (pix_vblank),
		.pix_vsync  (pix_vsync),
		.blend_en   (blend_en),
		.shadow_en  (shadow_en),
		.custom_pal (custom_pal),
		.pal_wr     (pal_wr),
		.pal_addr   (pal_addr),
		.pal_data   (pal_data),
		.rgb_r      (rgb_r),
		.rgb_g      (rgb_g),
		.rgb_b      (rgb_b),
		.de         (de)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic check_rgb(input gamate_video_pkg::rgb_t got, input gamate_video_pkg::rgb_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "wrong pixel colour");
		end
	endtask

	task automatic check_de(input bit got, input bit exp, input string what);
		if (got != exp) begin
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "wrong data enable");
		end
	endtask

	function automatic logic [CH_W-1:0] avg_ch(input logic [CH_W-1:0] c,
		input logic [CH_W-1:0] p);
		int sum;
		sum = int'(c) + int'(p);
		return CH_W'(sum / 2);
	endfunction

	// Shift-sum attenuation weighted by the shade above
	function automatic logic [CH_W-1:0] darken_ch(input logic [CH_W-1:0] v,
		input gamate_video_pkg::shade_e above);
		logic [1:0] ab;
		int s;
		ab = above;
		s = int'(v) / 2 + int'(v) / 4;
		if (ab[1] == 1'b0)
			s = s + int'(v) / 8;
		if (ab[0] == 1'b0)
			s = s + int'(v) / 16;
		return CH_W'(s);
	endfunction

	function automatic gamate_video_pkg::rgb_t expect_rgb(input gamate_video_pkg::shade_e cur,
		input gamate_video_pkg::shade_e prv, input gamate_video_pkg::shade_e above,
		input row_t row);
		gamate_video_pkg::palette_t pal;
		gamate_video_pkg::rgb_t c;
		gamate_video_pkg::rgb_t p;
		gamate_video_pkg::rgb_t o;
		pal = row.custom ? ref_custom : gamate_video_pkg::default_palette;
		c = pal[cur];
		p = pal[prv];
		o = c;
		if (row.blend) begin
			o.r = avg_ch(c.r, p.r);
			o.g = avg_ch(c.g, p.g);
			o.b = avg_ch(c.b, p.b);
		end
		if (row.shadow && cur == gamate_video_pkg::SHADE_0
			&& above != gamate_video_pkg::SHADE_0) begin
			o.r = darken_ch(o.r, above);
			o.g = darken_ch(o.g, above);
			o.b = darken_ch(o.b, above);
		end
		return o;
	endfunction

	task automatic next_shade(input logic [1:0] mode, input int x, input int y,
		output gamate_video_pkg::shade_e s);
		int r;
		r = $random(seed);
		case (mode)
			MODE_ZERO: s = gamate_video_pkg::SHADE_0;
			MODE_CHECKER: begin
				if ((x + y) % 2 == 1)
					s = gamate_video_pkg::shade_e'(2'(1 + y % 3));
				else
					s = gamate_video_pkg::SHADE_0;
			end
			default: s = gamate_video_pkg::shade_e'(r[1:0]);
		endcase
	endtask

	task automatic reset_model();
		ref_have_frame = 1'b0;
		ref_seen_active = 1'b0;
		ref_custom = gamate_video_pkg::custom_reset_palette;
	endtask

	// Holds rst_n low for 8 edges and then releases it
	task automatic hold_reset();
		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		check_de(de, 1'b0, "de in reset");
		check_rgb(gamate_video_pkg::rgb_t'({rgb_r, rgb_g, rgb_b}), '0, "rgb in reset");
		@(posedge clk_sys);
		rst_n <= 1'b1;
	endtask

	task automatic write_palette(input int count);
		int a;
		logic [7:0] d;
		for (int i = 0; i < count; i++) begin
			a = (wr_cnt * 7) % PAL_BYTES;
			d = WR_BYTES[wr_cnt % PAL_BYTES];
			@(posedge clk_sys);
			pal_wr <= 1'b1;
			pal_addr <= 4'(a);
			pal_data <= d;
			case (a % 3)
				0: ref_custom[a / 3].r = d;
				1: ref_custom[a / 3].g = d;
				default: ref_custom[a / 3].b = d;
			endcase
			wr_cnt = wr_cnt + 1;
		end
		@(posedge clk_sys);
		pal_wr <= 1'b0;
	endtask

	// One pixel slot of CE_DIV cycles
	// Lines 0 and 1 are vblank and line 0 carries vsync
	task automatic send_pixel(input row_t row, input int x, input int ln);
		gamate_video_pkg::shade_e s;
		gamate_video_pkg::shade_e prv;
		gamate_video_pkg::shade_e above;
		gamate_video_pkg::rgb_t exp_rgb;
		bit hb;
		bit vb;
		bit vs;
		bit active;
		int ay;
		hb = (x >= H_ACT);
		vb = (ln < V_BLANK);
		vs = (ln == 0);
		active = !hb && !vb;
		ay = ln - V_BLANK;
		above = gamate_video_pkg::SHADE_0;
		exp_rgb = '0;
		if (active)
			next_shade(row.mode, x, ay, s);
		else
			next_shade(MODE_RANDOM, x, ay, s);
		if (vs && ref_seen_active)
			ref_have_frame = 1'b1;
		if (!hb) begin
			above = ref_line[x];
			ref_line[x] = vb ? gamate_video_pkg::SHADE_0 : s;
		end
		if (active) begin
			prv = ref_have_frame ? ref_prev[ay * H_ACT + x] : s;
			ref_prev[ay * H_ACT + x] = s;
			ref_seen_active = 1'b1;
			exp_rgb = expect_rgb(s, prv, above, row);
		end
		@(posedge clk_sys);
		pix_ce <= 1'b1;
		pix_shade <= s;
		pix_hblank <= hb;
		pix_vblank <= vb;
		pix_vsync <= vs;
		@(posedge clk_sys);
		pix_ce <= 1'b0;
		@(negedge clk_sys);
		check_de(de, active, "de");
		check_rgb(gamate_video_pkg::rgb_t'({rgb_r, rgb_g, rgb_b}), exp_rgb, "rgb");
		repeat (CE_DIV - 2) @(posedge clk_sys);
	endtask

	task automatic run_lines(input row_t row, input int first_ln, input int last_ln);
		for (int ln = first_ln; ln < last_ln; ln++) begin
			for (int x = 0; x < H_ACT + H_BLANK; x++)
				send_pixel(row, x, ln);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		pix_ce = 1'b0;
		pix_shade = 2'd0;
		pix_hblank = 1'b0;
		pix_vblank = 1'b0;
		pix_vsync = 1'b0;
		blend_en = 1'b0;
		shadow_en = 1'b0;
		custom_pal = 1'b0;
		pal_wr = 1'b0;
		pal_addr = 4'd0;
		pal_data = 8'd0;
		for (int x = 0; x < H_ACT; x++)
			ref_line[x] = gamate_video_pkg::SHADE_0;
		reset_model();
		hold_reset();

		for (int i = 0; i < ROWS; i++) begin
			$display("row %0d: blend %0d shadow %0d custom %0d", i, ROW_TBL[i].blend,
				ROW_TBL[i].shadow, ROW_TBL[i].custom);
			@(posedge clk_sys);
			blend_en <= ROW_TBL[i].blend;
			shadow_en <= ROW_TBL[i].shadow;
			custom_pal <= ROW_TBL[i].custom;
			write_palette(int'(ROW_TBL[i].n_writes));
			if (ROW_TBL[i].mid_reset) begin
				// Break off just after the first pixel of an active line
				run_lines(ROW_TBL[i], 0, V_BLANK + V_ACT / 2);
				send_pixel(ROW_TBL[i], 0, V_BLANK + V_ACT / 2);
				@(posedge clk_sys);
				rst_n <= 1'b0;
				pix_ce <= 1'b0;
				pix_hblank <= 1'b0;
				pix_vblank <= 1'b0;
				pix_vsync <= 1'b0;
				reset_model();
				hold_reset();
			end
			for (int f = 0; f < FRAMES; f++)
				run_lines(ROW_TBL[i], 0, V_BLANK + V_ACT);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+logic
logic/gamate_video_pkg.sv
logic/pixel_if.sv
logic/frame_history.sv
logic/shadow_line.sv
logic/palette_blend.sv
logic/gamate_video.sv
tb/gamate_video_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the gamate_video testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module gamate_video_tb \
	-o gamate_video_sim

sim_out=$(./obj_dir/gamate_video_sim 2>&1) || true
echo "$sim_out"

if grep -qx '>>> PASS' <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
